// File: Bender.yml
package:
  name: lms_weight_update

sources:
  # package first, then the blocks, then the top level
  - rtl/lms_pkg.sv
  - rtl/tap_sequencer.sv
  - rtl/ref_delay_line.sv
  - rtl/weight_bank.sv
  - rtl/weight_update_mac.sv
  - rtl/lms_weight_update.sv

  - target: simulation
    files:
      - verification/lms_weight_update_checker.sv
      - verification/lms_weight_update_tb.sv

// File: rtl/lms_pkg.sv
`default_nettype none

package lms_pkg;

    localparam int NUM_TAPS    = 16;            // filter taps
    localparam int TAP_IDX_W   = 4;             // tap index width, holds 0..15
    localparam int SAMPLE_W    = 14;            // reference sample width
    localparam int ERR_W       = 11;            // error value width
    localparam int WEIGHT_W    = 31;            // weight width, sums wrap at 2**31

    // issue of a tap to its weight write landing in the bank
    localparam int MAC_LATENCY = 1;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,                        // waiting for update_start
        ST_ISSUE = 2'd1,                        // walking taps 0..NUM_TAPS-1
        ST_DRAIN = 2'd2                         // last tap still in the mac
    } seq_state_t;

endpackage

`default_nettype wire

// File: rtl/lms_weight_update.sv
`timescale 1ns/1ps
`default_nettype none

module lms_weight_update
    import lms_pkg::*;
#(
    parameter int NUM_TAPS = lms_pkg::NUM_TAPS,
    parameter int SAMPLE_W = lms_pkg::SAMPLE_W,
    parameter int ERR_W    = lms_pkg::ERR_W,
    parameter int WEIGHT_W = lms_pkg::WEIGHT_W
)
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [SAMPLE_W-1:0]  sample_in,
    input  logic                 sample_valid,
    input  logic [ERR_W-1:0]     err_in,
    input  logic                 update_start,
    input  logic [TAP_IDX_W-1:0] rd_idx,
    output logic [WEIGHT_W-1:0]  rd_weight,     // combinational readback
    output logic                 busy,
    output logic                 update_done
);

    logic [TAP_IDX_W-1:0] tap_idx;
    logic                 tap_valid;
    logic [ERR_W-1:0]     err_hold;
    logic [SAMPLE_W-1:0]  tap_sample;
    logic [WEIGHT_W-1:0]  cur_weight;
    logic                 wr_en;
    logic [TAP_IDX_W-1:0] wr_idx;
    logic [WEIGHT_W-1:0]  wr_weight;

    // producer, walks the taps once per start
    tap_sequencer #(
        .NUM_TAPS     (NUM_TAPS),
        .ERR_W        (ERR_W)
    ) i_tap_sequencer (
        .clk          (clk),
        .rstn         (rstn),
        .update_start (update_start),
        .err_in       (err_in),
        .tap_idx      (tap_idx),
        .tap_valid    (tap_valid),
        .err_hold     (err_hold),
        .busy         (busy),
        .update_done  (update_done)
    );

    ref_delay_line #(
        .NUM_TAPS     (NUM_TAPS),
        .SAMPLE_W     (SAMPLE_W)
    ) i_ref_delay_line (
        .clk          (clk),
        .rstn         (rstn),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .busy         (busy),           // line held still during a pass
        .tap_idx      (tap_idx),
        .tap_sample   (tap_sample)
    );

    weight_bank #(
        .NUM_TAPS     (NUM_TAPS),
        .WEIGHT_W     (WEIGHT_W)
    ) i_weight_bank (
        .clk          (clk),
        .rstn         (rstn),
        .tap_idx      (tap_idx),
        .rd_idx       (rd_idx),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_weight    (wr_weight),
        .cur_weight   (cur_weight),
        .rd_weight    (rd_weight)
    );

    // consumer, writes back one edge after each issue
    weight_update_mac #(
        .SAMPLE_W     (SAMPLE_W),
        .ERR_W        (ERR_W),
        .WEIGHT_W     (WEIGHT_W)
    ) i_weight_update_mac (
        .clk          (clk),
        .rstn         (rstn),
        .tap_valid    (tap_valid),
        .tap_idx      (tap_idx),
        .err_hold     (err_hold),
        .tap_sample   (tap_sample),
        .cur_weight   (cur_weight),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_weight    (wr_weight)
    );

endmodule

`default_nettype wire

// File: rtl/ref_delay_line.sv
`timescale 1ns/1ps
`default_nettype none

module ref_delay_line
    import lms_pkg::*;
#(
    parameter int NUM_TAPS = lms_pkg::NUM_TAPS,
    parameter int SAMPLE_W = lms_pkg::SAMPLE_W
)
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [SAMPLE_W-1:0]  sample_in,
    input  logic                 sample_valid,  // one-cycle strobe
    input  logic                 busy,          // freezes the line during a pass
    input  logic [TAP_IDX_W-1:0] tap_idx,
    output logic [SAMPLE_W-1:0]  tap_sample     // sample at tap_idx
);

    logic [SAMPLE_W-1:0] sample_q [NUM_TAPS];   // tap 0 is the newest
    logic                shift_en;

    // samples arriving mid-pass are lost, not queued
    assign shift_en = sample_valid && !busy;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < NUM_TAPS; i++)
            begin
                sample_q[i] <= '0;
            end
        end
        else if (shift_en)
        begin
            sample_q[0] <= sample_in;            // new sample into tap 0
            for (int i = 1; i < NUM_TAPS; i++)
            begin
                sample_q[i] <= sample_q[i-1];    // older samples move up
            end
        end
    end

    // indexed read, the sequencer never issues past the last tap
    assign tap_sample = sample_q[tap_idx];

endmodule

`default_nettype wire

// File: rtl/tap_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module tap_sequencer
    import lms_pkg::*;
#(
    parameter int NUM_TAPS = lms_pkg::NUM_TAPS,
    parameter int ERR_W    = lms_pkg::ERR_W
)
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 update_start,  // one-cycle strobe
    input  logic [ERR_W-1:0]     err_in,
    output logic [TAP_IDX_W-1:0] tap_idx,       // tap being issued
    output logic                 tap_valid,
    output logic [ERR_W-1:0]     err_hold,      // error frozen for the whole pass
    output logic                 busy,
    output logic                 update_done    // one-cycle pulse at end of pass
);

    localparam int DRAIN_W = (MAC_LATENCY > 1) ? $clog2(MAC_LATENCY) : 1;
    localparam logic [TAP_IDX_W-1:0] LAST_TAP = TAP_IDX_W'(NUM_TAPS - 1);
    localparam logic [DRAIN_W-1:0] LAST_DRAIN = DRAIN_W'(MAC_LATENCY - 1);

    seq_state_t           state;
    logic [TAP_IDX_W-1:0] tap_cnt;              // next tap to issue
    logic [DRAIN_W-1:0]   drain_cnt;            // cycles spent in drain
    logic                 accept;

    // starts while a pass is running are dropped
    assign accept = (state == ST_IDLE) && update_start && !busy;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state       <= ST_IDLE;
            tap_cnt     <= '0;
            drain_cnt   <= '0;
            tap_idx     <= '0;
            tap_valid   <= 1'b0;
            busy        <= 1'b0;
            update_done <= 1'b0;
        end
        else
        begin
            tap_valid   <= (state == ST_ISSUE);  // taps lag the counter by one edge
            tap_idx     <= tap_cnt;
            update_done <= 1'b0;                 // default, pulse only

            if (accept)
                busy <= 1'b1;
            else if (update_done)
                busy <= 1'b0;                    // drop one cycle after done

            case (state)
                ST_IDLE:
                begin
                    if (accept)
                    begin
                        state   <= ST_ISSUE;
                        tap_cnt <= '0;
                    end
                end
                ST_ISSUE:
                begin
                    tap_cnt <= tap_cnt + 1'b1;
                    if (tap_cnt == LAST_TAP)
                    begin
                        state     <= ST_DRAIN;
                        drain_cnt <= '0;
                    end
                end
                ST_DRAIN:
                begin
                    if (drain_cnt == LAST_DRAIN)
                    begin
                        state       <= ST_IDLE;
                        update_done <= 1'b1;
                    end
                    else
                        drain_cnt <= drain_cnt + 1'b1;
                end
                default:
                    state <= ST_IDLE;            // illegal encoding recovery
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            err_hold <= err_in;                  // sampled on the accepting edge only
    end

endmodule

`default_nettype wire

// File: rtl/weight_bank.sv
`timescale 1ns/1ps
`default_nettype none

module weight_bank
    import lms_pkg::*;
#(
    parameter int NUM_TAPS = lms_pkg::NUM_TAPS,
    parameter int WEIGHT_W = lms_pkg::WEIGHT_W
)
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic [TAP_IDX_W-1:0] tap_idx,       // update path read address
    input  logic [TAP_IDX_W-1:0] rd_idx,        // external readback address
    input  logic                 wr_en,
    input  logic [TAP_IDX_W-1:0] wr_idx,
    input  logic [WEIGHT_W-1:0]  wr_weight,
    output logic [WEIGHT_W-1:0]  cur_weight,    // old weight for the mac
    output logic [WEIGHT_W-1:0]  rd_weight
);

    logic [WEIGHT_W-1:0] weight_q [NUM_TAPS];

    // weights start from zero after reset
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < NUM_TAPS; i++)
            begin
                weight_q[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < NUM_TAPS; i++)
            begin
                if (wr_en && (wr_idx == TAP_IDX_W'(i)))
                    weight_q[i] <= wr_weight;    // single write port
            end
        end
    end

    // two independent read ports, no bypass from the write port
    assign cur_weight = weight_q[tap_idx];
    assign rd_weight  = weight_q[rd_idx];

endmodule

`default_nettype wire

// File: rtl/weight_update_mac.sv
`timescale 1ns/1ps
`default_nettype none

module weight_update_mac
    import lms_pkg::*;
#(
    parameter int SAMPLE_W = lms_pkg::SAMPLE_W,
    parameter int ERR_W    = lms_pkg::ERR_W,
    parameter int WEIGHT_W = lms_pkg::WEIGHT_W
)
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 tap_valid,
    input  logic [TAP_IDX_W-1:0] tap_idx,
    input  logic [ERR_W-1:0]     err_hold,
    input  logic [SAMPLE_W-1:0]  tap_sample,
    input  logic [WEIGHT_W-1:0]  cur_weight,
    output logic                 wr_en,         // one cycle per issued tap
    output logic [TAP_IDX_W-1:0] wr_idx,
    output logic [WEIGHT_W-1:0]  wr_weight
);

    localparam int PROD_W = ERR_W + SAMPLE_W;   // full unsigned product

    logic [PROD_W-1:0]   product;
    logic [WEIGHT_W-1:0] new_weight;

    assign product    = err_hold * tap_sample;  // unsigned, no overflow
    // wraps modulo 2**WEIGHT_W
    assign new_weight = cur_weight + WEIGHT_W'(product);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            wr_en <= 1'b0;
        else
            wr_en <= tap_valid;                  // strobe trails the issue by one edge
    end

    always_ff @(posedge clk)
    begin
        if (tap_valid)
        begin
            wr_idx    <= tap_idx;                // travels with its weight
            wr_weight <= new_weight;
        end
    end

endmodule

`default_nettype wire

// File: verification/lms_weight_update_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lms_weight_update_checker
    import lms_pkg::*;
(
    input wire logic clk,
    input wire logic rstn,
    input wire logic update_start,
    input wire logic tap_valid,
    input wire logic busy,
    input wire logic update_done
);

    // accepting edge to done, all taps plus the mac drain
    localparam int DONE_EDGES = NUM_TAPS + MAC_LATENCY;

    logic        start_accept;
    int unsigned fail_count = 0;                   // failed assertions so far

    assign start_accept = update_start && !busy;   // idle whenever busy is low

    property p_done_single;
        @(posedge clk) disable iff (!rstn)
        update_done |=> !update_done;
    endproperty

    property p_tap_in_pass;
        @(posedge clk) disable iff (!rstn)
        tap_valid |-> busy;
    endproperty

    property p_done_timing;
        @(posedge clk) disable iff (!rstn)
        start_accept |=> (!update_done) [*DONE_EDGES] ##1 update_done;
    endproperty

    property p_busy_falls;
        @(posedge clk) disable iff (!rstn)
        update_done |=> !busy;
    endproperty

    a_done_single: assert property (p_done_single)
        else
        begin
            fail_count++;
            $error("update_done high for two cycles in a row");
        end
    a_tap_in_pass: assert property (p_tap_in_pass)
        else
        begin
            fail_count++;
            $error("tap_valid high while busy is low");
        end
    a_done_timing: assert property (p_done_timing)
        else
        begin
            fail_count++;
            $error("update_done not exactly %0d edges after accepted start", DONE_EDGES);
        end
    a_busy_falls:  assert property (p_busy_falls)
        else
        begin
            fail_count++;
            $error("busy still high in the cycle after update_done");
        end

endmodule

bind tap_sequencer lms_weight_update_checker i_checker (
    .clk          (clk),
    .rstn         (rstn),
    .update_start (update_start),
    .tap_valid    (tap_valid),
    .busy         (busy),
    .update_done  (update_done)
);

`default_nettype wire

// File: verification/lms_weight_update_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lms_weight_update_tb
    import lms_pkg::*;
();

    localparam int DONE_EDGES    = NUM_TAPS + MAC_LATENCY;  // accepting edge to done
    localparam int DONE_TIMEOUT  = 64;                      // cycles before giving up
    localparam int WRAP_PASSES   = 72;                      // enough to pass 2**31
    localparam int RANDOM_PASSES = 20;

    logic                 clk;
    logic                 rstn;
    logic [SAMPLE_W-1:0]  sample_in;
    logic                 sample_valid;
    logic [ERR_W-1:0]     err_in;
    logic                 update_start;
    logic [TAP_IDX_W-1:0] rd_idx;
    logic [WEIGHT_W-1:0]  rd_weight;
    logic                 busy;
    logic                 update_done;

    logic [SAMPLE_W-1:0]  model_samples [NUM_TAPS];  // tap 0 newest
    logic [WEIGHT_W-1:0]  model_weights [NUM_TAPS];
    logic                 wrap_seen;                 // some sum crossed 2**31

    lms_weight_update #(
        .NUM_TAPS     (NUM_TAPS)
    ) i_dut (
        .clk          (clk),
        .rstn         (rstn),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .err_in       (err_in),
        .update_start (update_start),
        .rd_idx       (rd_idx),
        .rd_weight    (rd_weight),
        .busy         (busy),
        .update_done  (update_done)
    );

    always #4 clk = ~clk;                            // 8 ns period

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("error: %s actual 0x%0h expected 0x%0h", name, actual, expected);
            fail_run("value mismatch");
        end
    endtask

    // sequencer timing assertions bound inside the dut
    always @(negedge clk)
    begin
        if (i_dut.i_tap_sequencer.i_checker.fail_count != 0)
            fail_run("a sequencer timing assertion failed");
    end

    function automatic void model_shift(input logic [SAMPLE_W-1:0] value);
        for (int k = NUM_TAPS - 1; k > 0; k--)
        begin
            model_samples[k] = model_samples[k-1];   // older samples move up
        end
        model_samples[0] = value;
    endfunction

    // w = w + e * x, unsigned, kept modulo 2**31
    function automatic void model_pass(input logic [ERR_W-1:0] err);
        logic [63:0] sum;
        for (int k = 0; k < NUM_TAPS; k++)
        begin
            sum = 64'(model_weights[k]) + 64'(err) * 64'(model_samples[k]);
            if (sum >= 64'h8000_0000)
                wrap_seen = 1'b1;
            model_weights[k] = sum[WEIGHT_W-1:0];
        end
    endfunction

    task automatic shift_sample(input logic [SAMPLE_W-1:0] value);
        @(negedge clk);
        sample_in    = value;
        sample_valid = 1'b1;
        @(negedge clk);
        sample_valid = 1'b0;
        model_shift(value);
    endtask

    // one pass, optionally poking strobes that must be dropped
    task automatic run_pass(input logic [ERR_W-1:0] err, input bit disturb);
        int cycles;
        model_pass(err);
        @(negedge clk);
        err_in       = err;
        update_start = 1'b1;
        @(negedge clk);                              // edge 0 just accepted it
        update_start = 1'b0;
        err_in       = ~err;                         // later changes must not matter
        cycles       = 0;
        while (!update_done)
        begin
            check_value("busy", 64'(busy), 64'd1);
            if (disturb && (cycles == 5))
            begin
                sample_in    = SAMPLE_W'($urandom);
                sample_valid = 1'b1;
                update_start = 1'b1;
            end
            else
            begin
                sample_valid = 1'b0;
                update_start = 1'b0;
            end
            @(negedge clk);
            cycles++;
            if (cycles > DONE_TIMEOUT)
                fail_run("update_done never came after an accepted start");
        end
        check_value("done_edges", 64'(cycles), 64'(DONE_EDGES));
        check_value("busy", 64'(busy), 64'd1);      // last busy cycle
        if (disturb)
        begin
            update_start = 1'b1;                     // busy still high at this edge
            sample_valid = 1'b1;
        end
        @(negedge clk);
        update_start = 1'b0;
        sample_valid = 1'b0;
        check_value("busy", 64'(busy), 64'd0);
        check_value("update_done", 64'(update_done), 64'd0);
    endtask

    task automatic check_weights();
        for (int k = 0; k < NUM_TAPS; k++)
        begin
            @(negedge clk);
            rd_idx = TAP_IDX_W'(k);
            #2;                                      // combinational readback settles
            check_value($sformatf("rd_weight[%0d]", k), 64'(rd_weight),
                        64'(model_weights[k]));
        end
    endtask

    task automatic test_reset();
        check_value("busy", 64'(busy), 64'd0);
        check_value("update_done", 64'(update_done), 64'd0);
        check_weights();                             // model is all zero here
    endtask

    task automatic test_single_update();
        for (int k = 0; k < NUM_TAPS; k++)
        begin
            shift_sample(SAMPLE_W'(14'h0100 + 37 * k));
        end
        run_pass(11'h05a, 1'b0);
        check_weights();                             // weights were zero, so e * x
    endtask

    task automatic test_accumulate_wrap();
        wrap_seen = 1'b0;
        for (int k = 0; k < NUM_TAPS; k++)
        begin
            shift_sample(SAMPLE_W'(14'h3fff - k));   // near full scale
        end
        for (int p = 0; p < WRAP_PASSES; p++)
        begin
            shift_sample(SAMPLE_W'(14'h3f00 + ($urandom & 8'hff)));
            run_pass(ERR_W'(11'h7ff - p), 1'b0);
            if ((p % 8) == 7)
                check_weights();
        end
        check_weights();
        check_value("wrap_seen", 64'(wrap_seen), 64'd1);
    endtask

    task automatic test_dropped_strobes();
        run_pass(11'h123, 1'b1);                     // strobes mid-pass and at done
        check_weights();
        run_pass(11'h0f7, 1'b0);                     // samples must be unshifted
        check_weights();
    endtask

    task automatic test_random_passes();
        int n_shift;
        for (int p = 0; p < RANDOM_PASSES; p++)
        begin
            n_shift = 1 + ($urandom % NUM_TAPS);
            for (int s = 0; s < n_shift; s++)
            begin
                shift_sample(SAMPLE_W'($urandom));
            end
            run_pass(ERR_W'($urandom), 1'b0);
            check_weights();
        end
    endtask

    initial
    begin
        void'($urandom(32'hc31d));                   // fixed seed, once
        clk          = 1'b0;
        rstn         = 1'b0;
        sample_in    = '0;
        sample_valid = 1'b0;
        err_in       = '0;
        update_start = 1'b0;
        rd_idx       = '0;
        wrap_seen    = 1'b0;
        for (int k = 0; k < NUM_TAPS; k++)
        begin
            model_samples[k] = '0;
            model_weights[k] = '0;
        end
        repeat (10) @(negedge clk);                  // reset held 10 cycles
        rstn = 1'b1;
        @(negedge clk);

        test_reset();
        test_single_update();
        test_accumulate_wrap();
        test_dropped_strobes();
        test_random_passes();

        if (i_dut.i_tap_sequencer.i_checker.fail_count != 0)
            fail_run("a sequencer timing assertion failed");
        else
        begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/lms_pkg.sv
rtl/tap_sequencer.sv
rtl/ref_delay_line.sv
rtl/weight_bank.sv
rtl/weight_update_mac.sv
rtl/lms_weight_update.sv
verification/lms_weight_update_checker.sv
verification/lms_weight_update_tb.sv
